//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsystem
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SRCS      = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/cache_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cache_arbiter (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              icache_req,
    input  wire mem_pkg::addr_t    icache_addr,
    input  wire logic              dcache_req,
    input  wire mem_pkg::mem_req_t dcache_in,
    input  wire logic              mem_valid,
    input  wire mem_pkg::line_t    mem_rdata,
    output logic                   icache_complete,
    output logic                   dcache_complete,
    output mem_pkg::line_t         icache_data,
    output mem_pkg::line_t         dcache_data,
    output logic                   mem_req,
    output mem_pkg::mem_req_t      mem_out
);

    mem_pkg::arb_state_t state;
    logic                icache_pending;
    logic                dcache_pending;

    // a port still shows its request in the cycle of its completion pulse.
    assign icache_pending = icache_req && !icache_complete;
    assign dcache_pending = dcache_req && !dcache_complete;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= mem_pkg::idle;
            mem_req         <= 1'b0;
            icache_complete <= 1'b0;
            dcache_complete <= 1'b0;
        end else begin
            mem_req         <= 1'b0;
            icache_complete <= 1'b0;
            dcache_complete <= 1'b0;
            case (state)
                mem_pkg::idle: begin
                    if (icache_pending) begin  // instruction side wins a tie.
                        state   <= mem_pkg::wait_icache;
                        mem_req <= 1'b1;
                    end else if (dcache_pending) begin
                        state   <= mem_pkg::wait_dcache;
                        mem_req <= 1'b1;
                    end
                end
                mem_pkg::wait_icache: begin
                    if (mem_valid) begin
                        icache_complete <= 1'b1;
                        state           <= mem_pkg::idle;
                    end
                end
                mem_pkg::wait_dcache: begin
                    if (mem_valid) begin
                        dcache_complete <= 1'b1;
                        state           <= mem_pkg::idle;
                    end
                end
                default: state <= mem_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::idle) begin
            if (icache_pending) begin
                mem_out <= '{addr: icache_addr, wr: 1'b0, data: '0};  // fetch is read only.
            end else if (dcache_pending) begin
                mem_out <= dcache_in;
            end
        end
        if (mem_valid && state == mem_pkg::wait_icache) begin
            icache_data <= mem_rdata;
        end
        if (mem_valid && state == mem_pkg::wait_dcache) begin
            dcache_data <= mem_rdata;
        end
    end

    // memory only answers a granted request.
    valid_when_granted: assert property (
        @(posedge clk) disable iff (reset) mem_valid |-> state != mem_pkg::idle)
        else $error("mem_valid with no request in flight.");

    one_completion: assert property (
        @(posedge clk) disable iff (reset) !(icache_complete && dcache_complete))
        else $error("both completion pulses in one cycle.");

endmodule

`default_nettype wire

//--- src/dcache_port.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_port (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              dc_valid,
    input  wire mem_pkg::mem_req_t dc_req,
    input  wire logic              complete,
    input  wire mem_pkg::line_t    fill_data,
    output logic                   dc_done,
    output mem_pkg::line_t         dc_rdata,
    output logic                   req,
    output mem_pkg::mem_req_t      req_out
);

    mem_pkg::addr_t line_addr;
    mem_pkg::addr_t tag;
    mem_pkg::line_t line;
    logic           line_valid;
    logic           match;
    logic           read_hit;

    assign line_addr = dc_req.addr & ~mem_pkg::addr_t'(mem_pkg::line_bytes - 1);
    assign match     = line_valid && (tag == line_addr);
    assign read_hit  = match && !dc_req.wr;

    always_ff @(posedge clk) begin
        if (reset) begin
            dc_done    <= 1'b0;
            req        <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            dc_done <= 1'b0;
            if (complete) begin
                req     <= 1'b0;
                dc_done <= 1'b1;
                if (!req_out.wr) begin
                    line_valid <= 1'b1;  // writes never allocate.
                end
            end else if (dc_valid) begin
                if (read_hit) begin
                    dc_done <= 1'b1;
                end else begin
                    req <= 1'b1;  // read miss or any write.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            dc_rdata <= fill_data;  // a write returns its own line.
            if (!req_out.wr) begin
                line <= fill_data;
                tag  <= req_out.addr;
            end
        end else if (dc_valid) begin
            dc_rdata     <= line;
            req_out.addr <= line_addr;
            req_out.wr   <= dc_req.wr;
            req_out.data <= dc_req.wr ? dc_req.data : '0;
            // write-through update of the held line.
            if (dc_req.wr && match) begin
                line <= dc_req.data;
            end
        end
    end

    access_while_pending: assert property (
        @(posedge clk) disable iff (reset) dc_valid |-> !req)
        else $error("dc_valid while a line request is pending.");

endmodule

`default_nettype wire

//--- src/icache_port.sv
`timescale 1ns/100ps
`default_nettype none

module icache_port (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           fetch_valid,
    input  wire mem_pkg::addr_t fetch_addr,
    input  wire logic           complete,
    input  wire mem_pkg::line_t fill_data,
    output logic                fetch_done,
    output mem_pkg::line_t      fetch_data,
    output logic                req,
    output mem_pkg::addr_t      req_addr
);

    mem_pkg::addr_t line_addr;
    mem_pkg::addr_t tag;         // line address of the held line.
    mem_pkg::line_t line;
    logic           line_valid;
    logic           hit;

    assign line_addr = fetch_addr & ~mem_pkg::addr_t'(mem_pkg::line_bytes - 1);
    assign hit       = line_valid && (tag == line_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_done <= 1'b0;
            req        <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (complete) begin
                req        <= 1'b0;  // drop one cycle after the fill.
                fetch_done <= 1'b1;
                line_valid <= 1'b1;
            end else if (fetch_valid) begin
                if (hit) begin
                    fetch_done <= 1'b1;
                end else begin
                    req <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            line       <= fill_data;
            tag        <= req_addr;
            fetch_data <= fill_data;
        end else if (fetch_valid) begin
            fetch_data <= line;      // only used on a hit.
            req_addr   <= line_addr;
        end
    end

    // the fetch unit waits for fetch_done before the next fetch.
    fetch_while_pending: assert property (
        @(posedge clk) disable iff (reset) fetch_valid |-> !req)
        else $error("fetch_valid while a line request is pending.");

endmodule

`default_nettype wire

//--- src/mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl #(
    parameter int mem_lines   = 16,  // power of two.
    parameter int mem_latency = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              mem_req,
    input  wire mem_pkg::mem_req_t mem_in,
    output logic                   mem_valid,
    output mem_pkg::line_t         mem_rdata
);

    localparam int idx_bits = $clog2(mem_lines);
    localparam int words    = $bits(mem_pkg::line_t) / 32;

    mem_pkg::line_t          store [mem_lines];
    mem_pkg::line_t          data_pipe [mem_latency];
    logic [mem_latency-1:0]  valid_pipe;
    mem_pkg::addr_t          line_num;
    logic [idx_bits-1:0]     idx;
    mem_pkg::line_t          result;

    // line i, word w holds {i, w}.
    initial begin
        for (int i = 0; i < mem_lines; i++) begin
            for (int w = 0; w < words; w++) begin
                store[i][w*32 +: 32] = {16'(i), 16'(w)};
            end
        end
    end

    assign line_num = mem_in.addr / mem_pkg::addr_t'(mem_pkg::line_bytes);
    assign idx      = line_num[idx_bits-1:0];  // wraps into the store.
    assign result   = mem_in.wr ? mem_in.data : store[idx];

    always_ff @(posedge clk) begin
        if (mem_req && mem_in.wr) begin
            store[idx] <= mem_in.data;
        end
        data_pipe[0] <= result;
        for (int s = 1; s < mem_latency; s++) begin
            data_pipe[s] <= data_pipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mem_req;
            for (int s = 1; s < mem_latency; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    assign mem_valid = valid_pipe[mem_latency-1];
    assign mem_rdata = data_pipe[mem_latency-1];

    // the arbiter holds one request at a time.
    req_is_pulse: assert property (
        @(posedge clk) disable iff (reset) mem_req |=> !mem_req)
        else $error("mem_req high on two consecutive cycles.");

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // byte address and one full cache line.
    typedef logic [63:0]  addr_t;
    typedef logic [511:0] line_t;

    // bytes per line, so the low 6 address bits select within a line.
    localparam int line_bytes = 64;

    // one line transfer between a port, the arbiter and memory.
    typedef struct packed {
        addr_t addr;  // line address.
        logic  wr;    // 1 for a full-line write.
        line_t data;  // write data, zero for reads.
    } mem_req_t;

    typedef enum logic [1:0] {
        idle,
        wait_icache,
        wait_dcache
    } arb_state_t;

endpackage

`default_nettype wire

//--- src/mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem #(
    parameter int mem_lines   = 16,
    parameter int mem_latency = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              fetch_valid,
    input  wire mem_pkg::addr_t    fetch_addr,
    input  wire logic              dc_valid,
    input  wire mem_pkg::mem_req_t dc_req,
    output logic                   fetch_done,
    output mem_pkg::line_t         fetch_data,
    output logic                   dc_done,
    output mem_pkg::line_t         dc_rdata
);

    logic              icache_req;
    mem_pkg::addr_t    icache_addr;
    logic              icache_complete;
    mem_pkg::line_t    icache_data;
    logic              dcache_req;
    mem_pkg::mem_req_t dcache_out;
    logic              dcache_complete;
    mem_pkg::line_t    dcache_data;
    logic              mem_req;
    mem_pkg::mem_req_t mem_out;
    logic              mem_valid;
    mem_pkg::line_t    mem_rdata;

    icache_port icache0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_valid(fetch_valid),
        .fetch_addr (fetch_addr),
        .complete   (icache_complete),
        .fill_data  (icache_data),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .req        (icache_req),
        .req_addr   (icache_addr)
    );

    dcache_port dcache0 (
        .clk      (clk),
        .reset    (reset),
        .dc_valid (dc_valid),
        .dc_req   (dc_req),
        .complete (dcache_complete),
        .fill_data(dcache_data),
        .dc_done  (dc_done),
        .dc_rdata (dc_rdata),
        .req      (dcache_req),
        .req_out  (dcache_out)
    );

    cache_arbiter arb0 (
        .clk            (clk),
        .reset          (reset),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_in      (dcache_out),
        .mem_valid      (mem_valid),
        .mem_rdata      (mem_rdata),
        .icache_complete(icache_complete),
        .dcache_complete(dcache_complete),
        .icache_data    (icache_data),
        .dcache_data    (dcache_data),
        .mem_req        (mem_req),
        .mem_out        (mem_out)
    );

    mem_ctrl #(
        .mem_lines  (mem_lines),
        .mem_latency(mem_latency)
    ) mem0 (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_in   (mem_out),
        .mem_valid(mem_valid),
        .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- tb.f
src/mem_pkg.sv
src/icache_port.sv
src/dcache_port.sv
src/cache_arbiter.sv
src/mem_ctrl.sv
src/mem_subsystem.sv
test/mem_checker.sv
test/tb_mem_subsystem.sv

//--- test/mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_checker #(
    parameter int mem_lines   = 16,
    parameter int mem_latency = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              fetch_valid,
    input  wire mem_pkg::addr_t    fetch_addr,
    input  wire logic              dc_valid,
    input  wire mem_pkg::mem_req_t dc_req,
    input  wire logic              exp_hit,
    input  wire logic              fetch_done,
    input  wire mem_pkg::line_t    fetch_data,
    input  wire logic              dc_done,
    input  wire mem_pkg::line_t    dc_rdata,
    output int                     tests,
    output int                     errors
);

    mem_pkg::line_t mem_model [mem_lines];
    mem_pkg::line_t ic_line;
    mem_pkg::line_t dc_line;
    mem_pkg::addr_t ic_tag;
    mem_pkg::addr_t dc_tag;
    logic           ic_held;
    logic           dc_held;
    mem_pkg::line_t f_exp;
    mem_pkg::line_t d_exp;
    int             f_start;
    int             d_start;
    logic           f_hit;
    logic           d_hit;
    logic           d_waits;  // data side started with a fetch, so it queues.
    int             cycle;

    initial begin
        cycle  = 0;
        tests  = 0;
        errors = 0;
        for (int i = 0; i < mem_lines; i++) begin
            for (int w = 0; w < 16; w++) begin
                mem_model[i][w*32 +: 32] = {16'(i), 16'(w)};
            end
        end
    end

    function automatic int index_of(input mem_pkg::addr_t addr);
        return int'(addr / mem_pkg::addr_t'(mem_pkg::line_bytes)) % mem_lines;
    endfunction

    task automatic finish_test(input string name, input mem_pkg::line_t got,
                               input mem_pkg::line_t exp, input int lat, input logic hit,
                               input logic waited);
        int   want;
        logic ok;
        want = hit ? 1 : mem_latency + 4;
        ok   = 1'b1;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            ok = 1'b0;
        end
        if (waited ? lat <= want : lat != want) begin
            $display("%s came after %0d cycles, expected %s%0d.", name, lat,
                     waited ? "more than " : "", want);
            ok = 1'b0;
        end
        tests = tests + 1;
        if (!ok) begin
            errors = errors + 1;
        end
        $display("test %0d on %s: %s", tests, name, ok ? "ok" : "failed");
    endtask

    always @(posedge clk) begin
        mem_pkg::addr_t la;
        cycle = cycle + 1;
        if (reset) begin
            if (cycle > 1 && (fetch_done !== 1'b0 || dc_done !== 1'b0)) begin
                $display("a done output is high during reset.");
                errors = errors + 1;
            end
            ic_held = 1'b0;
            dc_held = 1'b0;
        end else begin
            if (fetch_done && dc_done) begin
                $display("fetch_done and dc_done pulsed in the same cycle.");
                errors = errors + 1;
            end
            if (fetch_done) begin
                finish_test("fetch_data", fetch_data, f_exp, cycle - f_start, f_hit, 1'b0);
            end
            if (dc_done) begin
                finish_test("dc_rdata", dc_rdata, d_exp, cycle - d_start, d_hit, d_waits);
            end
            if (fetch_valid) begin
                la = fetch_addr & ~mem_pkg::addr_t'(mem_pkg::line_bytes - 1);
                if (!(ic_held && ic_tag == la)) begin
                    ic_line = mem_model[index_of(fetch_addr)];
                    ic_tag  = la;
                    ic_held = 1'b1;
                end
                f_exp   = ic_line;
                f_hit   = exp_hit;
                f_start = cycle;
            end
            if (dc_valid) begin
                la = dc_req.addr & ~mem_pkg::addr_t'(mem_pkg::line_bytes - 1);
                if (dc_req.wr) begin
                    mem_model[index_of(dc_req.addr)] = dc_req.data;
                    if (dc_held && dc_tag == la) begin
                        dc_line = dc_req.data;
                    end
                    d_exp = dc_req.data;
                end else begin
                    if (!(dc_held && dc_tag == la)) begin
                        dc_line = mem_model[index_of(dc_req.addr)];
                        dc_tag  = la;
                        dc_held = 1'b1;
                    end
                    d_exp = dc_line;
                end
                d_hit   = exp_hit;
                d_start = cycle;
                d_waits = fetch_valid;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem;

    localparam int mem_lines    = 16;
    localparam int mem_latency  = 4;
    localparam int reset_cycles = 16;

    localparam logic [1:0] fetch_only = 2'd0;
    localparam logic [1:0] data_only  = 2'd1;
    localparam logic [1:0] both       = 2'd2;  // both valids in one cycle.

    typedef struct packed {
        logic [1:0]     sel;
        logic           wr;
        mem_pkg::addr_t addr;
        mem_pkg::line_t data;
        logic           hit;
    } entry_t;

    logic              clk;
    logic              reset;
    logic              fetch_valid;
    mem_pkg::addr_t    fetch_addr;
    logic              dc_valid;
    mem_pkg::mem_req_t dc_req;
    logic              exp_hit;
    logic              fetch_done;
    mem_pkg::line_t    fetch_data;
    logic              dc_done;
    mem_pkg::line_t    dc_rdata;
    int                tests;
    int                errors;
    entry_t            stim [$];
    int                seed;
    int                n_checks;
    int                limit;
    int                cycles;

    mem_subsystem #(
        .mem_lines  (mem_lines),
        .mem_latency(mem_latency)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_valid(fetch_valid),
        .fetch_addr (fetch_addr),
        .dc_valid   (dc_valid),
        .dc_req     (dc_req),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .dc_done    (dc_done),
        .dc_rdata   (dc_rdata)
    );

    mem_checker #(
        .mem_lines  (mem_lines),
        .mem_latency(mem_latency)
    ) check0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_valid(fetch_valid),
        .fetch_addr (fetch_addr),
        .dc_valid   (dc_valid),
        .dc_req     (dc_req),
        .exp_hit    (exp_hit),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .dc_done    (dc_done),
        .dc_rdata   (dc_rdata),
        .tests      (tests),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("run hung, no final done pulse within %0d cycles.", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic mem_pkg::line_t random_line();
        mem_pkg::line_t l;
        for (int k = 0; k < 16; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic add_entry(input logic [1:0] sel, input logic wr,
                             input mem_pkg::addr_t addr, input logic hit);
        entry_t e;
        e.sel    = sel;
        e.wr     = wr;
        e.addr   = addr;
        e.data   = wr ? random_line() : '0;
        e.hit    = hit;
        stim.push_back(e);
        n_checks = n_checks + ((sel == both) ? 2 : 1);
    endtask

    task automatic build_table();
        add_entry(fetch_only, 1'b0, 64'h0100, 1'b0);  // first fetch after reset.
        add_entry(fetch_only, 1'b0, 64'h0124, 1'b1);
        add_entry(data_only,  1'b0, 64'h0200, 1'b0);
        add_entry(data_only,  1'b0, 64'h0208, 1'b1);
        add_entry(data_only,  1'b0, 64'h1240, 1'b0);  // wraps to line 9.
        add_entry(data_only,  1'b1, 64'h1240, 1'b0);  // write to the held line.
        add_entry(data_only,  1'b0, 64'h1250, 1'b1);
        add_entry(data_only,  1'b1, 64'h0300, 1'b0);  // no allocate.
        add_entry(data_only,  1'b0, 64'h1248, 1'b1);
        add_entry(data_only,  1'b0, 64'h0300, 1'b0);
        add_entry(both,       1'b0, 64'h0580, 1'b0);
        add_entry(data_only,  1'b1, 64'h0700, 1'b0);
        add_entry(fetch_only, 1'b0, 64'h0710, 1'b0);  // sees the written line.
        add_entry(fetch_only, 1'b0, 64'h0700, 1'b1);
        add_entry(data_only,  1'b0, 64'h0700, 1'b0);
    endtask

    task automatic apply(input entry_t e);
        logic got_f;
        logic got_d;
        fetch_valid = e.sel != data_only;
        dc_valid    = e.sel != fetch_only;
        fetch_addr  = e.addr;
        dc_req      = '{addr: e.addr, wr: e.wr, data: e.data};
        exp_hit     = e.hit;
        got_f       = !fetch_valid;
        got_d       = !dc_valid;
        @(posedge clk);
        #2;
        fetch_valid = 1'b0;
        dc_valid    = 1'b0;
        got_f       = got_f || fetch_done;
        got_d       = got_d || dc_done;
        while (!(got_f && got_d)) begin
            @(posedge clk);
            #2;
            got_f = got_f || fetch_done;
            got_d = got_d || dc_done;
        end
    endtask

    initial begin
        seed        = 50;
        n_checks    = 0;
        cycles      = 0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        dc_valid    = 1'b0;
        dc_req      = '0;
        exp_hit     = 1'b0;
        build_table();
        limit = stim.size() * 2 * (mem_latency + 8) + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (stim[i]) begin
            apply(stim[i]);
        end
        @(posedge clk);
        #2;
        $display("%0d of %0d tests run, %0d errors.", tests, n_checks, errors);
        if (errors == 0 && tests == n_checks) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
